//--- all.f
src/core_pkg.sv
src/fetch_stage.sv
src/imem_model.sv
src/decode_unit.sv
src/execute_unit.sv
src/retire_unit.sv
src/fetch_core_top.sv
verification/tb_fetch_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch core testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tb_fetch_core -o sim_fetch_core

./obj_dir/sim_fetch_core | tee sim.log

# the testbench prints the fail message on any failed check or timeout
if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"

//--- src/core_pkg.sv
// shared types and encodings for the small core
// rv32 subset only: addi, beq, bne, jal
// register file is four entries, so index fields keep 2 bits
// cause codes follow the riscv mcause numbering

package core_pkg;

    // byte address of an instruction
    typedef logic [31:0] addr_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // register data value
    typedef logic [31:0] xlen_t;
    // register index, x0 to x3 only
    typedef logic [1:0]  reg_idx_t;

    // next pc select driven by retire
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'd0,
        NEXT_PC_SEL_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP = 2'd2
    } next_pc_sel_t;

    // decoded operation
    typedef enum logic [2:0] {
        OP_ADDI    = 3'd0,
        OP_BEQ     = 3'd1,
        OP_BNE     = 3'd2,
        OP_JAL     = 3'd3,
        OP_ILLEGAL = 3'd4
    } op_t;

    // exception causes, riscv codes
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        ILLEGAL_INSTR         = 4'd2,
        INSTR_PAGE_FAULT      = 4'd12
    } exc_cause_t;

    // major opcodes
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values inside the opcodes above
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

endpackage

//--- src/decode_unit.sv
// decode for addi, beq, bne and jal
// any other encoding is illegal, the all-zero word included
// a used register field above 3 is also illegal
// illegal_o is only raised for a valid fetch packet

module decode_unit import core_pkg::*; (
    input  inst_t    inst_i,
    input  logic     valid_i,
    output op_t      op_o,
    output reg_idx_t rd_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output xlen_t    imm_o,
    output logic     illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       rd_hi;
    logic       rs1_hi;
    logic       rs2_hi;
    xlen_t      imm_i_type;
    xlen_t      imm_b_type;
    xlen_t      imm_j_type;
    logic       bad;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // register fields beyond x3
    assign rd_hi  = |inst_i[11:9];
    assign rs1_hi = |inst_i[19:17];
    assign rs2_hi = |inst_i[24:22];

    assign rd_o  = inst_i[8:7];
    assign rs1_o = inst_i[16:15];
    assign rs2_o = inst_i[21:20];

    // sign-extended immediates
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        op_o  = OP_ILLEGAL;
        imm_o = '0;
        bad   = 1'b1;
        case (opcode)
            OPC_OPIMM: begin
                if (funct3 == F3_ADDI && !rd_hi && !rs1_hi) begin
                    op_o  = OP_ADDI;
                    imm_o = imm_i_type;
                    bad   = 1'b0;
                end
            end
            OPC_BRANCH: begin
                // only rs1 and rs2 are register fields here
                if (!rs1_hi && !rs2_hi) begin
                    if (funct3 == F3_BEQ) begin
                        op_o  = OP_BEQ;
                        imm_o = imm_b_type;
                        bad   = 1'b0;
                    end else if (funct3 == F3_BNE) begin
                        op_o  = OP_BNE;
                        imm_o = imm_b_type;
                        bad   = 1'b0;
                    end
                end
            end
            OPC_JAL: begin
                if (!rd_hi) begin
                    op_o  = OP_JAL;
                    imm_o = imm_j_type;
                    bad   = 1'b0;
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
    end

    assign illegal_o = valid_i && bad;

endmodule

//--- src/execute_unit.sv
// execute: four-entry register file, addi, branches, jal
// x0 is never written, so it reads zero after reset
// the write happens at the edge only when retire commits

module execute_unit import core_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     commit_i,
    input  addr_t    pc_i,
    input  op_t      op_i,
    input  reg_idx_t rd_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  xlen_t    imm_i,
    output logic     wb_en_o,
    output xlen_t    wb_value_o,
    output reg_idx_t rd_o,
    output logic     redirect_o,
    output addr_t    target_o
);

    xlen_t regs [4];
    xlen_t rs1_val;
    xlen_t rs2_val;
    logic  equal;

    assign rs1_val = regs[rs1_i];
    assign rs2_val = regs[rs2_i];
    assign equal   = rs1_val == rs2_val;

    // writeback value, link is pc + 4
    always_comb begin
        case (op_i)
            OP_ADDI: wb_value_o = rs1_val + imm_i;
            OP_JAL:  wb_value_o = pc_i + 32'd4;
            default: wb_value_o = '0;
        endcase
    end

    assign wb_en_o = (op_i == OP_ADDI) || (op_i == OP_JAL);
    assign rd_o    = rd_i;

    // jal always, branches when the compare holds
    assign redirect_o = (op_i == OP_JAL) ||
                        (op_i == OP_BEQ && equal) ||
                        (op_i == OP_BNE && !equal);
    assign target_o   = pc_i + imm_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i && wb_en_o && (rd_i != 2'd0)) begin
            regs[rd_i] <= wb_value_o;
        end
    end

endmodule

//--- src/fetch_core_top.sv
// top level of the small core: fetch, memory, decode, execute, retire
// one instruction in flight, one retire per unstalled cycle
// load the memory only while stall_i is high

module fetch_core_top import core_pkg::*; #(
    parameter int    MEM_WORDS = 64,
    parameter addr_t RESET_PC  = 32'h0,
    parameter addr_t TRAP_VEC  = 32'h80,
    parameter addr_t PF_BASE   = 32'hC0,
    parameter addr_t PF_SIZE   = 32'h20
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       stall_i,
    // memory load port
    input  logic       load_en_i,
    input  addr_t      load_addr_i,
    input  inst_t      load_data_i,
    // retire report
    output logic       retire_valid_o,
    output addr_t      retire_pc_o,
    output inst_t      retire_inst_o,
    output logic       trap_valid_o,
    output exc_cause_t trap_cause_o,
    output logic       wb_en_o,
    output reg_idx_t   wb_rd_o,
    output xlen_t      wb_value_o
);

    // fetch to memory
    logic         imem_req;
    addr_t        imem_addr;
    logic         rsp_valid;
    inst_t        rsp_data;
    logic         rsp_access_fault;
    logic         rsp_page_fault;
    // fetch packet
    logic         fetch_valid;
    addr_t        fetch_pc;
    inst_t        fetch_inst;
    logic         fetch_ex_valid;
    exc_cause_t   fetch_ex_cause;
    // decode results
    op_t          dec_op;
    reg_idx_t     dec_rd;
    reg_idx_t     dec_rs1;
    reg_idx_t     dec_rs2;
    xlen_t        dec_imm;
    logic         dec_illegal;
    // execute results
    logic         ex_wb_en;
    xlen_t        ex_wb_value;
    reg_idx_t     ex_rd;
    logic         ex_redirect;
    addr_t        ex_target;
    // retire control
    logic         commit;
    next_pc_sel_t next_pc_sel;
    addr_t        jump_pc;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .stall_i            (stall_i),
        .next_pc_sel_i      (next_pc_sel),
        .jump_pc_i          (jump_pc),
        .rsp_valid_i        (rsp_valid),
        .rsp_data_i         (rsp_data),
        .rsp_access_fault_i (rsp_access_fault),
        .rsp_page_fault_i   (rsp_page_fault),
        .imem_req_o         (imem_req),
        .imem_addr_o        (imem_addr),
        .fetch_valid_o      (fetch_valid),
        .fetch_pc_o         (fetch_pc),
        .fetch_inst_o       (fetch_inst),
        .fetch_ex_valid_o   (fetch_ex_valid),
        .fetch_ex_cause_o   (fetch_ex_cause)
    );

    imem_model #(
        .MEM_WORDS (MEM_WORDS),
        .PF_BASE   (PF_BASE),
        .PF_SIZE   (PF_SIZE)
    ) u_imem (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .req_i              (imem_req),
        .addr_i             (imem_addr),
        .load_en_i          (load_en_i),
        .load_addr_i        (load_addr_i),
        .load_data_i        (load_data_i),
        .rsp_valid_o        (rsp_valid),
        .rsp_data_o         (rsp_data),
        .rsp_access_fault_o (rsp_access_fault),
        .rsp_page_fault_o   (rsp_page_fault)
    );

    decode_unit u_decode (
        .inst_i    (fetch_inst),
        .valid_i   (fetch_valid),
        .op_o      (dec_op),
        .rd_o      (dec_rd),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .imm_o     (dec_imm),
        .illegal_o (dec_illegal)
    );

    execute_unit u_execute (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .commit_i   (commit),
        .pc_i       (fetch_pc),
        .op_i       (dec_op),
        .rd_i       (dec_rd),
        .rs1_i      (dec_rs1),
        .rs2_i      (dec_rs2),
        .imm_i      (dec_imm),
        .wb_en_o    (ex_wb_en),
        .wb_value_o (ex_wb_value),
        .rd_o       (ex_rd),
        .redirect_o (ex_redirect),
        .target_o   (ex_target)
    );

    retire_unit #(
        .TRAP_VEC (TRAP_VEC)
    ) u_retire (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .fetch_inst_i     (fetch_inst),
        .fetch_ex_valid_i (fetch_ex_valid),
        .fetch_ex_cause_i (fetch_ex_cause),
        .illegal_i        (dec_illegal),
        .wb_en_i          (ex_wb_en),
        .wb_value_i       (ex_wb_value),
        .rd_i             (ex_rd),
        .redirect_i       (ex_redirect),
        .target_i         (ex_target),
        .commit_o         (commit),
        .next_pc_sel_o    (next_pc_sel),
        .jump_pc_o        (jump_pc),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_inst_o    (retire_inst_o),
        .trap_valid_o     (trap_valid_o),
        .trap_cause_o     (trap_cause_o),
        .wb_en_o          (wb_en_o),
        .wb_rd_o          (wb_rd_o),
        .wb_value_o       (wb_value_o)
    );

endmodule

//--- src/fetch_stage.sv
// fetch stage: pc register, next pc mux, memory request
// misalignment is detected here, access and page faults come
// from the memory response in the same cycle
// a misaligned pc or a stall makes no memory request

module fetch_stage import core_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         stall_i,
    // select and target from retire
    input  next_pc_sel_t next_pc_sel_i,
    input  addr_t        jump_pc_i,
    // memory response
    input  logic         rsp_valid_i,
    input  inst_t        rsp_data_i,
    input  logic         rsp_access_fault_i,
    input  logic         rsp_page_fault_i,
    // memory request
    output logic         imem_req_o,
    output addr_t        imem_addr_o,
    // fetch packet
    output logic         fetch_valid_o,
    output addr_t        fetch_pc_o,
    output inst_t        fetch_inst_o,
    output logic         fetch_ex_valid_o,
    output exc_cause_t   fetch_ex_cause_o
);

    addr_t pc;
    addr_t next_pc;

    logic ex_misaligned;
    logic ex_access_fault;
    logic ex_page_fault;

    // next pc mux
    always_comb begin
        case (next_pc_sel_i)
            NEXT_PC_SEL_PC:   next_pc = pc;
            NEXT_PC_SEL_PC_4: next_pc = pc + 32'd4;
            NEXT_PC_SEL_JUMP: next_pc = jump_pc_i;
            default:          next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // low pc bits must be zero
    assign ex_misaligned   = |pc[1:0];
    // memory faults only count with a valid response
    assign ex_access_fault = rsp_valid_i && rsp_access_fault_i;
    assign ex_page_fault   = rsp_valid_i && rsp_page_fault_i;

    assign imem_req_o  = !ex_misaligned && !stall_i;
    assign imem_addr_o = pc;

    // priority: misaligned, access fault, page fault
    always_comb begin
        fetch_ex_valid_o = 1'b1;
        if (ex_misaligned) begin
            fetch_ex_cause_o = INSTR_ADDR_MISALIGNED;
        end else if (ex_access_fault) begin
            fetch_ex_cause_o = INSTR_ACCESS_FAULT;
        end else if (ex_page_fault) begin
            fetch_ex_cause_o = INSTR_PAGE_FAULT;
        end else begin
            fetch_ex_cause_o = INSTR_ADDR_MISALIGNED;
            fetch_ex_valid_o = 1'b0;
        end
    end

    // packet valid on a response or on any fetch exception
    assign fetch_valid_o = rsp_valid_i || fetch_ex_valid_o;
    assign fetch_pc_o    = pc;
    assign fetch_inst_o  = rsp_data_i;

endmodule

//--- src/imem_model.sv
// word-addressed instruction memory model, combinational read
// MEM_WORDS must be at least 2; low two address bits are ignored
// words at or beyond MEM_WORDS give an access fault
// addresses in [PF_BASE, PF_BASE + PF_SIZE) give a page fault
// loads beyond the depth are dropped, faulting reads return zero

module imem_model import core_pkg::*; #(
    parameter int    MEM_WORDS = 64,
    parameter addr_t PF_BASE   = 32'hC0,
    parameter addr_t PF_SIZE   = 32'h20
) (
    input  logic  clk_i,
    input  logic  rstn_i,
    // read request
    input  logic  req_i,
    input  addr_t addr_i,
    // load port
    input  logic  load_en_i,
    input  addr_t load_addr_i,
    input  inst_t load_data_i,
    // read response
    output logic  rsp_valid_o,
    output inst_t rsp_data_o,
    output logic  rsp_access_fault_o,
    output logic  rsp_page_fault_o
);

    localparam int AW = $clog2(MEM_WORDS);

    inst_t mem [MEM_WORDS];

    logic [29:0] rd_word;
    logic [29:0] ld_word;
    logic        rd_in_range;
    logic        rd_in_window;

    assign rd_word = addr_i[31:2];
    assign ld_word = load_addr_i[31:2];

    // load port, ignored while in reset
    always_ff @(posedge clk_i) begin
        if (load_en_i && rstn_i && (ld_word < 30'(MEM_WORDS))) begin
            mem[ld_word[AW-1:0]] <= load_data_i;
        end
    end

    assign rd_in_range  = rd_word < 30'(MEM_WORDS);
    assign rd_in_window = (addr_i >= PF_BASE) && (addr_i < PF_BASE + PF_SIZE);

    // response in the same cycle as the request
    assign rsp_valid_o        = req_i;
    assign rsp_access_fault_o = req_i && !rd_in_range;
    assign rsp_page_fault_o   = req_i && rd_in_window;

    always_comb begin
        if (req_i && rd_in_range && !rd_in_window) begin
            rsp_data_o = mem[rd_word[AW-1:0]];
        end else begin
            rsp_data_o = '0;
        end
    end

endmodule

//--- src/retire_unit.sv
// retire: commit or trap, next pc select back to fetch
// fetch exceptions rank above the illegal flag from decode
// the report registers at the edge after the fetch cycle
// and is a one-cycle strobe

module retire_unit import core_pkg::*; #(
    parameter addr_t TRAP_VEC = 32'h80
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         stall_i,
    // fetch packet
    input  logic         fetch_valid_i,
    input  addr_t        fetch_pc_i,
    input  inst_t        fetch_inst_i,
    input  logic         fetch_ex_valid_i,
    input  exc_cause_t   fetch_ex_cause_i,
    // decode and execute results
    input  logic         illegal_i,
    input  logic         wb_en_i,
    input  xlen_t        wb_value_i,
    input  reg_idx_t     rd_i,
    input  logic         redirect_i,
    input  addr_t        target_i,
    // control back to fetch and execute
    output logic         commit_o,
    output next_pc_sel_t next_pc_sel_o,
    output addr_t        jump_pc_o,
    // retire report
    output logic         retire_valid_o,
    output addr_t        retire_pc_o,
    output inst_t        retire_inst_o,
    output logic         trap_valid_o,
    output exc_cause_t   trap_cause_o,
    output logic         wb_en_o,
    output reg_idx_t     wb_rd_o,
    output xlen_t        wb_value_o
);

    logic       fire;
    logic       trap;
    exc_cause_t cause;

    // one instruction leaves per unstalled cycle
    assign fire  = fetch_valid_i && !stall_i;
    assign trap  = fire && (fetch_ex_valid_i || illegal_i);
    assign cause = fetch_ex_valid_i ? fetch_ex_cause_i : ILLEGAL_INSTR;

    assign commit_o = fire && !trap;

    // hold on stall, trap vector on exception, target on redirect
    always_comb begin
        jump_pc_o = target_i;
        if (stall_i) begin
            next_pc_sel_o = NEXT_PC_SEL_PC;
        end else if (trap) begin
            next_pc_sel_o = NEXT_PC_SEL_JUMP;
            jump_pc_o     = TRAP_VEC;
        end else if (commit_o && redirect_i) begin
            next_pc_sel_o = NEXT_PC_SEL_JUMP;
        end else begin
            next_pc_sel_o = NEXT_PC_SEL_PC_4;
        end
    end

    // report strobes
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            retire_valid_o <= 1'b0;
            trap_valid_o   <= 1'b0;
            wb_en_o        <= 1'b0;
        end else begin
            retire_valid_o <= fire;
            trap_valid_o   <= trap;
            wb_en_o        <= commit_o && wb_en_i;
        end
    end

    // report payload
    always_ff @(posedge clk_i) begin
        retire_pc_o   <= fetch_pc_i;
        retire_inst_o <= fetch_inst_i;
        trap_cause_o  <= cause;
        wb_rd_o       <= rd_i;
        wb_value_o    <= wb_value_i;
    end

endmodule

//--- verification/tb_fetch_core.sv
// directed testbench for fetch_core_top with default parameters
// a behavioral model of pc and registers predicts every retire
// programs go in through the load port while the core is stalled
// memory keeps its contents across the per-test resets
// program addresses must stay below 32'h100

module tb_fetch_core import core_pkg::*; ();

    localparam int    PERIOD         = 40;
    localparam int    RESET_CYCLES   = 5;
    localparam int    MEM_WORDS      = 64;
    localparam addr_t RESET_PC       = 32'h0;
    localparam addr_t TRAP_VEC       = 32'h80;
    localparam addr_t PF_BASE        = 32'hC0;
    localparam addr_t PF_SIZE        = 32'h20;
    localparam int    NUM_TESTS      = 5;
    localparam int    RETIRE_WAIT    = 4;
    localparam int    TIMEOUT_CYCLES = NUM_TESTS * 200 + RESET_CYCLES + MEM_WORDS;

    logic       clk;
    logic       rstn;
    logic       stall;
    logic       load_en;
    addr_t      load_addr;
    inst_t      load_data;
    logic       retire_valid;
    addr_t      retire_pc;
    inst_t      retire_inst;
    logic       trap_valid;
    exc_cause_t trap_cause;
    logic       wb_en;
    reg_idx_t   wb_rd;
    xlen_t      wb_value;

    // model image of memory and the fields each word was built from
    inst_t      tb_mem [MEM_WORDS];
    op_t        m_op   [MEM_WORDS];
    logic [4:0] m_rd   [MEM_WORDS];
    logic [4:0] m_rs1  [MEM_WORDS];
    logic [4:0] m_rs2  [MEM_WORDS];
    xlen_t      m_imm  [MEM_WORDS];
    // architectural model state
    xlen_t      m_regs [4];
    addr_t      m_pc;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    fetch_core_top u_dut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .stall_i        (stall),
        .load_en_i      (load_en),
        .load_addr_i    (load_addr),
        .load_data_i    (load_data),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_inst_o  (retire_inst),
        .trap_valid_o   (trap_valid),
        .trap_cause_o   (trap_cause),
        .wb_en_o        (wb_en),
        .wb_rd_o        (wb_rd),
        .wb_value_o     (wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // watchdog sized from the per-test budget
    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // signed 12-bit immediate for addi
    function automatic xlen_t rand_imm12();
        logic [11:0] r;
        r = 12'(rand_bits(12));
        return {{20{r[11]}}, r};
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            $display("mismatch %s: got %h, expected %h", name, got, expv);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int e0);
        $display("test %s finished with %0d errors", name, errors - e0);
    endtask

    // encode one instruction and record it for the model before loading it
    task automatic put_instr(input addr_t addr, input op_t op, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2, input xlen_t imm);
        inst_t w;
        case (op)
            OP_ADDI: w = {imm[11:0], rs1, F3_ADDI, rd, OPC_OPIMM};
            OP_BEQ:  w = {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OPC_BRANCH};
            OP_BNE:  w = {imm[12], imm[10:5], rs2, rs1, F3_BNE, imm[4:1], imm[11], OPC_BRANCH};
            OP_JAL:  w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            default: w = '0;
        endcase
        tb_mem[addr[7:2]] = w;
        m_op[addr[7:2]]   = op;
        m_rd[addr[7:2]]   = rd;
        m_rs1[addr[7:2]]  = rs1;
        m_rs2[addr[7:2]]  = rs2;
        m_imm[addr[7:2]]  = imm;
        @(posedge clk);
        #2;
        load_en   = 1'b1;
        load_addr = addr;
        load_data = w;
    endtask

    // reset leaves the core stalled at RESET_PC
    task automatic apply_reset();
        @(posedge clk);
        #2;
        stall   = 1'b1;
        load_en = 1'b0;
        rstn    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;
        m_pc = RESET_PC;
        for (int i = 0; i < 4; i++) begin
            m_regs[i] = '0;
        end
    endtask

    // predict one retire from the model and compare it with the next strobe
    task automatic expect_retire();
        addr_t      e_pc;
        inst_t      e_inst;
        logic       e_trap;
        exc_cause_t e_cause;
        logic       e_wb;
        reg_idx_t   e_rd;
        xlen_t      e_value;
        addr_t      next;
        logic [5:0] w;
        logic       bad;
        xlen_t      a;
        xlen_t      b;
        int         waited;
        e_pc    = m_pc;
        e_inst  = '0;
        e_trap  = 1'b1;
        e_cause = ILLEGAL_INSTR;
        e_wb    = 1'b0;
        e_rd    = '0;
        e_value = '0;
        bad     = 1'b0;
        next    = m_pc + 32'd4;
        w       = m_pc[7:2];
        // fetch faults in priority order
        // a faulting fetch reports a zero word
        if (m_pc[1:0] != 2'b00) begin
            e_cause = INSTR_ADDR_MISALIGNED;
        end else if (m_pc >= addr_t'(MEM_WORDS * 4)) begin
            e_cause = INSTR_ACCESS_FAULT;
        end else if (m_pc >= PF_BASE && m_pc < PF_BASE + PF_SIZE) begin
            e_cause = INSTR_PAGE_FAULT;
        end else begin
            e_inst = tb_mem[w];
            a      = m_regs[m_rs1[w][1:0]];
            b      = m_regs[m_rs2[w][1:0]];
            // only x0..x3 exist
            case (m_op[w])
                OP_ADDI:        bad = (m_rd[w] > 5'd3) || (m_rs1[w] > 5'd3);
                OP_BEQ, OP_BNE: bad = (m_rs1[w] > 5'd3) || (m_rs2[w] > 5'd3);
                OP_JAL:         bad = m_rd[w] > 5'd3;
                default:        bad = 1'b1;
            endcase
            e_trap = bad;
            if (!bad) begin
                case (m_op[w])
                    OP_ADDI: begin
                        e_wb    = 1'b1;
                        e_rd    = m_rd[w][1:0];
                        e_value = a + m_imm[w];
                    end
                    OP_BEQ: begin
                        if (a == b) begin
                            next = m_pc + m_imm[w];
                        end
                    end
                    OP_BNE: begin
                        if (a != b) begin
                            next = m_pc + m_imm[w];
                        end
                    end
                    default: begin
                        // jal links pc + 4
                        e_wb    = 1'b1;
                        e_rd    = m_rd[w][1:0];
                        e_value = m_pc + 32'd4;
                        next    = m_pc + m_imm[w];
                    end
                endcase
            end
        end
        if (e_trap) begin
            next = TRAP_VEC;
        end
        // x0 stays zero
        if (e_wb && e_rd != 2'd0) begin
            m_regs[e_rd] = e_value;
        end
        m_pc = next;

        waited = 0;
        @(negedge clk);
        while (!retire_valid && waited < RETIRE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!retire_valid) begin
            $display("no retire strobe for pc %h within %0d cycles", e_pc, RETIRE_WAIT);
            errors++;
        end else begin
            compare_field("retire_pc_o", retire_pc, e_pc);
            compare_field("retire_inst_o", retire_inst, e_inst);
            compare_field("trap_valid_o", 32'(trap_valid), 32'(e_trap));
            compare_field("wb_en_o", 32'(wb_en), 32'(e_wb));
            if (e_trap) begin
                compare_field("trap_cause_o", 32'(trap_cause), 32'(e_cause));
            end
            if (e_wb) begin
                compare_field("wb_rd_o", 32'(wb_rd), 32'(e_rd));
                compare_field("wb_value_o", wb_value, e_value);
            end
        end
    endtask

    // unstall for n retires and stall again after the last fetch
    task automatic run_steps(input int n);
        @(posedge clk);
        #2;
        load_en = 1'b0;
        stall   = 1'b0;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #2;
            if (i == n - 1) begin
                stall = 1'b1;
            end
            expect_retire();
        end
    endtask

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            checks++;
            if (retire_valid) begin
                $display("retire strobe for pc %h while stalled", retire_pc);
                errors++;
            end
        end
    endtask

    task automatic test_addi_chain();
        int    e0;
        xlen_t imm [5];
        e0 = errors;
        apply_reset();
        for (int i = 0; i < 5; i++) begin
            imm[i] = rand_imm12();
        end
        put_instr(32'h00, OP_ADDI, 5'd1, 5'd0, 5'd0, imm[0]);
        put_instr(32'h04, OP_ADDI, 5'd2, 5'd1, 5'd0, imm[1]);
        put_instr(32'h08, OP_ADDI, 5'd3, 5'd2, 5'd0, imm[2]);
        // write to x0 is dropped
        put_instr(32'h0C, OP_ADDI, 5'd0, 5'd3, 5'd0, imm[3]);
        // reads x0 back so the value is the bare immediate
        put_instr(32'h10, OP_ADDI, 5'd1, 5'd0, 5'd0, imm[4]);
        put_instr(32'h14, OP_ADDI, 5'd2, 5'd1, 5'd0, 32'd0);
        run_steps(6);
        report_test("addi_chain", e0);
    endtask

    task automatic test_branches();
        int e0;
        e0 = errors;
        apply_reset();
        put_instr(32'h00, OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
        put_instr(32'h04, OP_ADDI, 5'd2, 5'd0, 5'd0, 32'd5);
        // taken beq skips 0x0c
        put_instr(32'h08, OP_BEQ, 5'd0, 5'd1, 5'd2, 32'd8);
        put_instr(32'h0C, OP_ADDI, 5'd3, 5'd0, 5'd0, 32'd1);
        // bne not taken and then bne taken over 0x18
        put_instr(32'h10, OP_BNE, 5'd0, 5'd1, 5'd2, 32'd8);
        put_instr(32'h14, OP_BNE, 5'd0, 5'd1, 5'd0, 32'd8);
        put_instr(32'h18, OP_ADDI, 5'd3, 5'd0, 5'd0, 32'd2);
        // beq not taken
        put_instr(32'h1C, OP_BEQ, 5'd0, 5'd1, 5'd0, 32'd8);
        put_instr(32'h20, OP_JAL, 5'd3, 5'd0, 5'd0, 32'd12);
        put_instr(32'h2C, OP_ADDI, 5'd1, 5'd3, 5'd0, 32'd0);
        // backward taken branch to 0x00
        put_instr(32'h30, OP_BEQ, 5'd0, 5'd1, 5'd3, 32'hFFFF_FFD0);
        run_steps(10);
        report_test("branches", e0);
    endtask

    task automatic test_stall();
        int e0;
        e0 = errors;
        apply_reset();
        // x3 held the jal link 0x24 before this reset
        // so the first sum shows whether reset cleared it
        put_instr(32'h00, OP_ADDI, 5'd1, 5'd3, 5'd0, rand_imm12());
        put_instr(32'h04, OP_ADDI, 5'd2, 5'd1, 5'd0, rand_imm12());
        put_instr(32'h08, OP_ADDI, 5'd3, 5'd2, 5'd0, rand_imm12());
        put_instr(32'h0C, OP_ADDI, 5'd1, 5'd3, 5'd0, rand_imm12());
        put_instr(32'h10, OP_ADDI, 5'd2, 5'd1, 5'd0, rand_imm12());
        put_instr(32'h14, OP_ADDI, 5'd3, 5'd2, 5'd0, rand_imm12());
        // model pc carries across the gaps, so a skip or repeat shows up
        run_steps(2);
        check_idle(4);
        run_steps(1);
        check_idle(2);
        run_steps(3);
        report_test("stall", e0);
    endtask

    task automatic test_fetch_faults();
        int e0;
        e0 = errors;
        // jump to a halfword address
        apply_reset();
        put_instr(32'h00, OP_JAL, 5'd1, 5'd0, 5'd0, 32'h22);
        run_steps(3);
        // jump past the memory depth
        apply_reset();
        put_instr(32'h00, OP_JAL, 5'd0, 5'd0, 5'd0, 32'h100);
        run_steps(3);
        // jump into the protected window
        apply_reset();
        put_instr(32'h00, OP_JAL, 5'd2, 5'd0, 5'd0, 32'hC4);
        run_steps(3);
        report_test("fetch_faults", e0);
    endtask

    task automatic test_illegal();
        int e0;
        e0 = errors;
        apply_reset();
        put_instr(32'h00, OP_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'd0);
        run_steps(2);
        // rd = x5 does not exist
        apply_reset();
        put_instr(32'h00, OP_ADDI, 5'd5, 5'd1, 5'd0, 32'd7);
        run_steps(2);
        // misaligned target inside the page-fault window where misaligned must win
        apply_reset();
        put_instr(32'h00, OP_JAL, 5'd1, 5'd0, 5'd0, 32'hC2);
        run_steps(3);
        report_test("illegal", e0);
    endtask

    initial begin
        rstn      = 1'b0;
        stall     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = 32'h81a883c0;
        errors    = 0;
        checks    = 0;
        apply_reset();
        // fill every word with a nop carrying its word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            put_instr(addr_t'(i * 4), OP_ADDI, 5'd0, 5'd0, 5'd0, xlen_t'(i));
        end
        test_addi_chain();
        test_branches();
        test_stall();
        test_fetch_faults();
        test_illegal();
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
